// File: periph_top.f
common/per_bus_pkg.sv
common/periph_pkg.sv
rtl/per_bus_ctrl.sv
uart/uart_regs.sv
uart/uart_tx.sv
uart/uart_rx.sv
gpio/gpio_regs.sv
rtl/periph_top.sv
tb/periph_top_asserts.sv
tb/tb_periph_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_periph_top \
    -f periph_top.f -o sim_periph_top

./obj_dir/sim_periph_top +verilator+error+limit+100 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: tb/tb_periph_top.sv
`timescale 1ns/10ps
module tb_periph_top import per_bus_pkg::*, periph_pkg::*;
();

    localparam int TEST_PRER    = 3;                   // Short bits keep frames fast
    localparam int FRAME_CYC    = FRAME_BITS * (TEST_PRER + 1);
    localparam int WATCHDOG_CYC = 20 * FRAME_CYC + 1000;  // 20 frames plus bus traffic

    logic                   i_mclk;
    logic                   i_rst_n;
    per_addr_t              i_per_addr;
    per_data_t              i_per_din;
    logic                   i_per_en;
    logic   [PER_WEW-1:0]   i_per_we;
    wire                    i_uart_rxd;
    byte_t                  i_port0_in;
    byte_t                  i_port1_in;
    per_data_t              o_per_dout;
    logic                   o_uart_txd;
    byte_t                  o_port0_out;
    byte_t                  o_port0_oe;
    byte_t                  o_port1_out;
    byte_t                  o_port1_oe;

    logic                   rxd_drv;                   // Line level when not looped back
    logic                   loop_en;
    int                     errors;
    logic   [31:0]          lcg_state;

    assign i_uart_rxd = loop_en ? o_uart_txd : rxd_drv; // TX to RX tie

    periph_top i_periph_top (
        .i_mclk         (i_mclk),
        .i_rst_n        (i_rst_n),
        .i_per_addr     (i_per_addr),
        .i_per_din      (i_per_din),
        .i_per_en       (i_per_en),
        .i_per_we       (i_per_we),
        .i_uart_rxd     (i_uart_rxd),
        .i_port0_in     (i_port0_in),
        .i_port1_in     (i_port1_in),
        .o_per_dout     (o_per_dout),
        .o_uart_txd     (o_uart_txd),
        .o_port0_out    (o_port0_out),
        .o_port0_oe     (o_port0_oe),
        .o_port1_out    (o_port1_out),
        .o_port1_oe     (o_port1_oe)
    );

    initial begin
        i_mclk = 1'b0;
        forever #5 i_mclk = ~i_mclk;                   // 10 ns period
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge i_mclk);
        $display("Watchdog expired after %0d cycles, the run timed out", WATCHDOG_CYC);
        $display("TEST FAIL");
        $finish;
    end

    // Helpers --------
    function automatic byte_t next_rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];                       // Upper bits, better spread
    endfunction

    function automatic per_addr_t uart_addr(input logic [2:0] idx);
        return UART_BASE | per_addr_t'(idx);
    endfunction

    function automatic per_addr_t gpio_addr(input logic [2:0] idx);
        return GPIO_BASE | per_addr_t'(idx);
    endfunction

    function automatic per_data_t stat_bit(input int pos);
        return per_data_t'(1) << pos;
    endfunction

    task automatic release_reset();
        @(posedge i_mclk);
        i_rst_n <= 1'b1;
    endtask

    task automatic set_loopback(input logic en);
        @(posedge i_mclk);
        loop_en <= en;
    endtask

    task automatic set_pins(input byte_t p0, input byte_t p1);
        @(posedge i_mclk);
        i_port0_in <= p0;
        i_port1_in <= p1;
    endtask

    // Bus cycles --------
    task automatic write_reg(input per_addr_t addr, input per_data_t data,
                             input logic [PER_WEW-1:0] we);
        @(posedge i_mclk);
        i_per_addr <= addr;
        i_per_din  <= data;
        i_per_en   <= 1'b1;
        i_per_we   <= we;
        @(posedge i_mclk);                             // Write lands on this edge
        i_per_en   <= 1'b0;
        i_per_we   <= '0;
    endtask

    task automatic read_reg(input per_addr_t addr, output per_data_t data);
        @(posedge i_mclk);
        i_per_addr <= addr;
        i_per_en   <= 1'b1;
        i_per_we   <= '0;
        @(negedge i_mclk);                             // Combinational read data settled
        data = o_per_dout;
        @(posedge i_mclk);
        i_per_en   <= 1'b0;
    endtask

    task automatic expect_reg(input per_addr_t addr, input per_data_t exp,
                              input per_data_t mask, input string name);
        per_data_t act;
        read_reg(addr, act);
        assert ((act & mask) == (exp & mask)) else begin
            errors++;
            $display("[ERROR] %0t o_per_dout (%s): expected %h, got %h",
                     $time, name, exp & mask, act & mask);
        end
    endtask

    task automatic poll_stat(input int pos, input logic level);
        per_data_t stat;
        read_reg(uart_addr(UART_STAT), stat);
        while (stat[pos] != level) begin               // Watchdog bounds this loop
            read_reg(uart_addr(UART_STAT), stat);
        end
    endtask

    task automatic drive_frame(input byte_t data, input logic stop_level);
        logic [FRAME_BITS-1:0] bits;
        bits = {stop_level, data, 1'b0};               // Stop, data, start
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(posedge i_mclk);
            rxd_drv <= bits[i];
            repeat (TEST_PRER) @(posedge i_mclk);
        end
        @(posedge i_mclk);
        rxd_drv <= 1'b1;                               // Back to idle
    endtask

    // Test sequence --------
    initial begin
        byte_t b0;
        byte_t b1;
        byte_t d0;
        byte_t o0;
        byte_t d1;
        byte_t o1;
        byte_t p0;
        byte_t p1;
        errors     = 0;
        lcg_state  = 32'ha7cf2f2d;
        i_rst_n    = 1'b0;
        i_per_addr = '0;
        i_per_din  = '0;
        i_per_en   = 1'b0;
        i_per_we   = '0;
        i_port0_in = '0;
        i_port1_in = '0;
        rxd_drv    = 1'b1;
        loop_en    = 1'b1;
        repeat (3) @(posedge i_mclk);
        release_reset();                               // Low for 4 edges

        expect_reg(uart_addr(UART_STAT), '0, '1, "UART_STAT");
        expect_reg(uart_addr(UART_PRER), PRER_RESET, '1, "UART_PRER");
        expect_reg(gpio_addr(GPIO_DIR0), '0, '1, "GPIO_DIR0");
        expect_reg(14'h0100, '0, '1, "unmapped");      // Outside both blocks

        // GPIO
        for (int n = 0; n < 4; n++) begin
            d0 = next_rand_byte();
            o0 = next_rand_byte();
            d1 = next_rand_byte();
            o1 = next_rand_byte();
            write_reg(gpio_addr(GPIO_DIR0), {8'h00, d0}, 2'b01);
            write_reg(gpio_addr(GPIO_OUT0), {8'h00, o0}, 2'b01);
            write_reg(gpio_addr(GPIO_DIR1), {8'h00, d1}, 2'b01);
            write_reg(gpio_addr(GPIO_OUT1), {8'h00, o1}, 2'b11); // Upper lane ignored
            expect_reg(gpio_addr(GPIO_DIR0), {8'h00, d0}, '1, "GPIO_DIR0");
            expect_reg(gpio_addr(GPIO_OUT0), {8'h00, o0}, '1, "GPIO_OUT0");
            expect_reg(gpio_addr(GPIO_DIR1), {8'h00, d1}, '1, "GPIO_DIR1");
            expect_reg(gpio_addr(GPIO_OUT1), {8'h00, o1}, '1, "GPIO_OUT1");
            p0 = next_rand_byte();
            p1 = next_rand_byte();
            set_pins(p0, p1);
            repeat (2) @(posedge i_mclk);              // Synchronizer depth
            expect_reg(gpio_addr(GPIO_IN0), {8'h00, p0}, '1, "GPIO_IN0");
            expect_reg(gpio_addr(GPIO_IN1), {8'h00, p1}, '1, "GPIO_IN1");
        end

        // UART loopback
        write_reg(uart_addr(UART_PRER), 16'(TEST_PRER), 2'b11);
        expect_reg(uart_addr(UART_PRER), 16'(TEST_PRER), '1, "UART_PRER");
        for (int n = 0; n < 4; n++) begin
            b0 = next_rand_byte();
            write_reg(uart_addr(UART_TXDATA), {8'h00, b0}, 2'b01);
            poll_stat(STAT_RXVALID, 1'b1);
            expect_reg(uart_addr(UART_STAT), '0, stat_bit(STAT_RXERR), "STAT_RXERR");
            expect_reg(uart_addr(UART_RXDATA), {8'h00, b0}, '1, "UART_RXDATA");
            write_reg(uart_addr(UART_STAT), stat_bit(STAT_RXVALID), 2'b01); // W1C
            expect_reg(uart_addr(UART_STAT), '0, stat_bit(STAT_RXVALID), "STAT_RXVALID");
            poll_stat(STAT_TXBUSY, 1'b0);
        end

        // Second byte while busy
        b0 = next_rand_byte();
        b1 = ~b0;                                      // Must differ from b0
        write_reg(uart_addr(UART_TXDATA), {8'h00, b0}, 2'b01);
        poll_stat(STAT_TXBUSY, 1'b1);
        write_reg(uart_addr(UART_TXDATA), {8'h00, b1}, 2'b01);
        poll_stat(STAT_RXVALID, 1'b1);
        expect_reg(uart_addr(UART_RXDATA), {8'h00, b0}, '1, "UART_RXDATA");
        write_reg(uart_addr(UART_STAT), stat_bit(STAT_RXVALID), 2'b01);
        poll_stat(STAT_TXBUSY, 1'b0);
        repeat (2 * FRAME_CYC) @(posedge i_mclk);      // Room for a stray frame
        expect_reg(uart_addr(UART_STAT), '0, stat_bit(STAT_RXVALID), "STAT_RXVALID");

        // Low stop bit
        set_loopback(1'b0);
        b0 = next_rand_byte();
        drive_frame(b0, 1'b0);
        poll_stat(STAT_RXVALID, 1'b1);
        expect_reg(uart_addr(UART_STAT), stat_bit(STAT_RXVALID) | stat_bit(STAT_RXERR),
                   stat_bit(STAT_RXVALID) | stat_bit(STAT_RXERR), "UART_STAT");

        $display("Readback errors: %0d, assertion failures: %0d",
                 errors, i_periph_top.m_asserts0.fail_cnt);
        if (errors == 0 && i_periph_top.m_asserts0.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb/periph_top_asserts.sv
`timescale 1ns/10ps
module periph_top_asserts import per_bus_pkg::*, periph_pkg::*;
(
    input   logic                   i_mclk,
    input   logic                   i_rst_n,
    input   per_addr_t              i_per_addr,
    input   per_data_t              i_per_din,
    input   logic                   i_per_en,
    input   logic   [PER_WEW-1:0]   i_per_we,
    input   per_data_t              i_per_dout,
    input   logic                   i_uart_txd,
    input   byte_t                  i_port0_out,
    input   byte_t                  i_port0_oe,
    input   byte_t                  i_port1_out,
    input   byte_t                  i_port1_oe
);

    byte_t  dir0_sh;                                   // Shadows built from bus writes
    byte_t  out0_sh;
    byte_t  dir1_sh;
    byte_t  out1_sh;
    logic   gpio_wr;
    int     fail_cnt = 0;                              // Read by the testbench at the end

    assign gpio_wr = i_per_en & i_per_we[0]
                   & (i_per_addr[PER_AW-1:BLK_SPAN_W] == GPIO_BASE[PER_AW-1:BLK_SPAN_W]);

    // Shadow registers --------
    always_ff @(posedge i_mclk) begin
        if (!i_rst_n) begin
            dir0_sh <= '0;
            out0_sh <= '0;
            dir1_sh <= '0;
            out1_sh <= '0;
        end else if (gpio_wr) begin
            case (i_per_addr[BLK_SPAN_W-1:0])
                GPIO_DIR0: dir0_sh <= i_per_din[BYTE_W-1:0];
                GPIO_OUT0: out0_sh <= i_per_din[BYTE_W-1:0];
                GPIO_DIR1: dir1_sh <= i_per_din[BYTE_W-1:0];
                GPIO_OUT1: out1_sh <= i_per_din[BYTE_W-1:0];
                default: ;                             // Input registers are read only
            endcase
        end
    end

    // Properties --------
    a_reset_state: assert property (@(posedge i_mclk) $rose(i_rst_n) |->
        i_uart_txd && i_port0_oe == '0 && i_port1_oe == '0
        && i_port0_out == '0 && i_port1_out == '0)
        else begin fail_cnt++; $error("Outputs not at reset values when reset ends"); end

    a_txd_idle: assert property (@(posedge i_mclk) !i_rst_n |=> i_uart_txd)
        else begin fail_cnt++; $error("UART line not high after a reset edge"); end

    a_idle_bus: assert property (@(posedge i_mclk) (!i_per_en || i_per_we != '0) |->
        i_per_dout == '0)
        else begin fail_cnt++; $error("Read data nonzero outside a read cycle"); end

    a_port0: assert property (@(posedge i_mclk) disable iff (!i_rst_n)
        i_port0_out == out0_sh && i_port0_oe == dir0_sh)
        else begin fail_cnt++; $error("Port 0 differs from the last bus writes"); end

    a_port1: assert property (@(posedge i_mclk) disable iff (!i_rst_n)
        i_port1_out == out1_sh && i_port1_oe == dir1_sh)
        else begin fail_cnt++; $error("Port 1 differs from the last bus writes"); end

endmodule

bind periph_top periph_top_asserts m_asserts0 (
    .i_mclk         (i_mclk),
    .i_rst_n        (i_rst_n),
    .i_per_addr     (i_per_addr),
    .i_per_din      (i_per_din),
    .i_per_en       (i_per_en),
    .i_per_we       (i_per_we),
    .i_per_dout     (o_per_dout),
    .i_uart_txd     (o_uart_txd),
    .i_port0_out    (o_port0_out),
    .i_port0_oe     (o_port0_oe),
    .i_port1_out    (o_port1_out),
    .i_port1_oe     (o_port1_oe)
);

// File: rtl/periph_top.sv
`timescale 1ns/10ps
module periph_top import per_bus_pkg::*, periph_pkg::*;
(
    input   logic                   i_mclk,
    input   logic                   i_rst_n,
    input   per_addr_t              i_per_addr,
    input   per_data_t              i_per_din,
    input   logic                   i_per_en,
    input   logic   [PER_WEW-1:0]   i_per_we,
    input   logic                   i_uart_rxd,
    input   byte_t                  i_port0_in,
    input   byte_t                  i_port1_in,

    output  per_data_t              o_per_dout,
    output  logic                   o_uart_txd,
    output  byte_t                  o_port0_out,
    output  byte_t                  o_port0_oe,
    output  byte_t                  o_port1_out,
    output  byte_t                  o_port1_oe
);

    logic                   uart_sel;
    logic                   gpio_sel;
    reg_idx_t               reg_idx;
    logic                   wr_lo;
    logic                   wr_hi;
    per_data_t              wdata;
    per_data_t              uart_rdata;
    per_data_t              gpio_rdata;

    logic                   tx_start;
    byte_t                  tx_byte;
    logic   [PRER_W-1:0]    prer;
    logic                   tx_busy;
    byte_t                  rx_byte;
    logic                   rx_done;
    logic                   rx_err;

    // Bus --------
    per_bus_ctrl m_bus_ctrl0 (
        .i_per_addr     (i_per_addr),
        .i_per_din      (i_per_din),
        .i_per_en       (i_per_en),
        .i_per_we       (i_per_we),
        .i_uart_rdata   (uart_rdata),
        .i_gpio_rdata   (gpio_rdata),
        .o_uart_sel     (uart_sel),
        .o_gpio_sel     (gpio_sel),
        .o_reg_idx      (reg_idx),
        .o_wr_lo        (wr_lo),
        .o_wr_hi        (wr_hi),
        .o_wdata        (wdata),
        .o_per_dout     (o_per_dout)
    );

    // UART --------
    uart_regs m_uart_regs0 (
        .i_mclk         (i_mclk),
        .i_rst_n        (i_rst_n),
        .i_sel          (uart_sel),
        .i_reg_idx      (reg_idx),
        .i_wr_lo        (wr_lo),
        .i_wr_hi        (wr_hi),
        .i_wdata        (wdata),
        .i_tx_busy      (tx_busy),
        .i_rx_byte      (rx_byte),
        .i_rx_done      (rx_done),
        .i_rx_err       (rx_err),
        .o_rdata        (uart_rdata),
        .o_tx_start     (tx_start),
        .o_tx_byte      (tx_byte),
        .o_prer         (prer)
    );

    uart_tx m_uart_tx0 (
        .i_mclk         (i_mclk),
        .i_rst_n        (i_rst_n),
        .i_start        (tx_start),
        .i_byte         (tx_byte),
        .i_prer         (prer),
        .o_txd          (o_uart_txd),
        .o_busy         (tx_busy),
        .o_done         ()
    );

    uart_rx m_uart_rx0 (
        .i_mclk         (i_mclk),
        .i_rst_n        (i_rst_n),
        .i_rxd          (i_uart_rxd),                  // Asynchronous pin
        .i_prer         (prer),
        .o_byte         (rx_byte),
        .o_done         (rx_done),
        .o_err          (rx_err)
    );

    // GPIO --------
    gpio_regs m_gpio_regs0 (
        .i_mclk         (i_mclk),
        .i_rst_n        (i_rst_n),
        .i_sel          (gpio_sel),
        .i_reg_idx      (reg_idx),
        .i_wr_lo        (wr_lo),
        .i_wdata        (wdata),
        .i_port0_in     (i_port0_in),
        .i_port1_in     (i_port1_in),
        .o_rdata        (gpio_rdata),
        .o_port0_out    (o_port0_out),
        .o_port0_oe     (o_port0_oe),
        .o_port1_out    (o_port1_out),
        .o_port1_oe     (o_port1_oe)
    );

endmodule

// File: gpio/gpio_regs.sv
`timescale 1ns/10ps
module gpio_regs import per_bus_pkg::*, periph_pkg::*;
(
    input   logic           i_mclk,
    input   logic           i_rst_n,
    input   logic           i_sel,
    input   reg_idx_t       i_reg_idx,
    input   logic           i_wr_lo,
    input   per_data_t      i_wdata,
    input   byte_t          i_port0_in,
    input   byte_t          i_port1_in,

    output  per_data_t      o_rdata,
    output  byte_t          o_port0_out,
    output  byte_t          o_port0_oe,
    output  byte_t          o_port1_out,
    output  byte_t          o_port1_oe
);

    byte_t  dir_q   [2];                               // 1 = output
    byte_t  out_q   [2];
    byte_t  in_meta [2];
    byte_t  in_sync [2];                               // Pins after two flops
    logic   wr;

    assign wr = i_sel & i_wr_lo;                       // Byte registers, low lane only

    always_ff @(posedge i_mclk) begin
        if (!i_rst_n) begin
            dir_q <= '{default: '0};                   // All pins input
            out_q <= '{default: '0};
        end else if (wr) begin
            if (i_reg_idx == GPIO_DIR0) dir_q[0] <= i_wdata[BYTE_W-1:0];
            if (i_reg_idx == GPIO_OUT0) out_q[0] <= i_wdata[BYTE_W-1:0];
            if (i_reg_idx == GPIO_DIR1) dir_q[1] <= i_wdata[BYTE_W-1:0];
            if (i_reg_idx == GPIO_OUT1) out_q[1] <= i_wdata[BYTE_W-1:0];
        end
    end

    // Input sync --------
    always_ff @(posedge i_mclk) begin
        in_meta[0] <= i_port0_in;
        in_meta[1] <= i_port1_in;
        in_sync    <= in_meta;
    end

    always_comb begin
        case (i_reg_idx)
            GPIO_DIR0: o_rdata = {{(PER_DW-BYTE_W){1'b0}}, dir_q[0]};
            GPIO_OUT0: o_rdata = {{(PER_DW-BYTE_W){1'b0}}, out_q[0]};
            GPIO_IN0:  o_rdata = {{(PER_DW-BYTE_W){1'b0}}, in_sync[0]};
            GPIO_DIR1: o_rdata = {{(PER_DW-BYTE_W){1'b0}}, dir_q[1]};
            GPIO_OUT1: o_rdata = {{(PER_DW-BYTE_W){1'b0}}, out_q[1]};
            GPIO_IN1:  o_rdata = {{(PER_DW-BYTE_W){1'b0}}, in_sync[1]};
            default:   o_rdata = '0;
        endcase
    end

    assign o_port0_out = out_q[0];
    assign o_port0_oe  = dir_q[0];                     // Pad enable from direction
    assign o_port1_out = out_q[1];
    assign o_port1_oe  = dir_q[1];

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/10ps
module uart_rx import periph_pkg::*;
(
    input   logic                   i_mclk,
    input   logic                   i_rst_n,
    input   logic                   i_rxd,
    input   logic   [PRER_W-1:0]    i_prer,

    output  byte_t                  o_byte,
    output  logic                   o_done,
    output  logic                   o_err
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t              state;
    logic                   rxd_meta;                  // First sync stage
    logic                   rxd_sync;                  // Second sync stage
    logic                   rxd_prev;                  // For falling edge
    logic   [PRER_W-1:0]    baud_cnt;
    logic   [2:0]           bit_cnt;                   // Data bit index
    byte_t                  shreg;

    // Synchronizer --------
    always_ff @(posedge i_mclk) begin
        if (!i_rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // Frame FSM --------
    always_ff @(posedge i_mclk) begin
        if (!i_rst_n) begin
            state    <= RX_IDLE;
            o_done   <= 1'b0;
            o_err    <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            o_done <= 1'b0;
            if (state != RX_IDLE && baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                case (state)
                    RX_IDLE: if (rxd_prev && !rxd_sync) begin
                        state    <= RX_START;
                        baud_cnt <= i_prer >> 1;       // Half bit to the middle
                    end
                    RX_START: begin
                        state    <= rxd_sync ? RX_IDLE : RX_DATA; // False start aborts
                        baud_cnt <= i_prer;
                        bit_cnt  <= '0;
                    end
                    RX_DATA: begin
                        baud_cnt <= i_prer;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(BYTE_W - 1)) state <= RX_STOP;
                    end
                    default: begin                     // Mid stop bit
                        state  <= RX_IDLE;
                        o_done <= 1'b1;
                        o_err  <= ~rxd_sync;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_mclk) begin
        if (state == RX_DATA && baud_cnt == '0) shreg <= {rxd_sync, shreg[BYTE_W-1:1]};
    end

    assign o_byte = shreg;

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/10ps
module uart_tx import periph_pkg::*;
(
    input   logic                   i_mclk,
    input   logic                   i_rst_n,
    input   logic                   i_start,
    input   byte_t                  i_byte,
    input   logic   [PRER_W-1:0]    i_prer,

    output  logic                   o_txd,
    output  logic                   o_busy,
    output  logic                   o_done
);

    logic   [PRER_W-1:0]    baud_cnt;                  // Cycles left in current bit
    logic   [3:0]           bit_cnt;                   // 0 = start bit, 9 = stop bit
    logic   [BYTE_W:0]      shreg;                     // Data bits with stop bit on top

    always_ff @(posedge i_mclk) begin
        if (!i_rst_n) begin
            o_txd    <= 1'b1;                          // Line idles high
            o_busy   <= 1'b0;
            o_done   <= 1'b0;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else begin
            o_done <= 1'b0;
            if (!o_busy) begin
                if (i_start) begin
                    o_txd    <= 1'b0;                  // Start bit
                    o_busy   <= 1'b1;
                    bit_cnt  <= '0;
                    baud_cnt <= i_prer;
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                o_busy <= 1'b0;                        // End of stop bit
                o_done <= 1'b1;
            end else begin
                o_txd    <= shreg[0];                  // LSB first
                bit_cnt  <= bit_cnt + 1'b1;
                baud_cnt <= i_prer;
            end
        end
    end

    // Shift path --------
    always_ff @(posedge i_mclk) begin
        if (!o_busy && i_start) begin
            shreg <= {1'b1, i_byte};
        end else if (o_busy && baud_cnt == '0) begin
            shreg <= {1'b1, shreg[BYTE_W:1]};          // Fill with stop level
        end
    end

endmodule

// File: uart/uart_regs.sv
`timescale 1ns/10ps
module uart_regs import per_bus_pkg::*, periph_pkg::*;
(
    input   logic                   i_mclk,
    input   logic                   i_rst_n,
    input   logic                   i_sel,
    input   reg_idx_t               i_reg_idx,
    input   logic                   i_wr_lo,
    input   logic                   i_wr_hi,
    input   per_data_t              i_wdata,
    input   logic                   i_tx_busy,
    input   byte_t                  i_rx_byte,
    input   logic                   i_rx_done,
    input   logic                   i_rx_err,

    output  per_data_t              o_rdata,
    output  logic                   o_tx_start,
    output  byte_t                  o_tx_byte,
    output  logic   [PRER_W-1:0]    o_prer
);

    logic   [PRER_W-1:0]    prer_q;                    // Clocks per bit minus one
    byte_t                  tx_byte_q;                 // Byte handed to the transmitter
    byte_t                  rx_buf_q;                  // Last received byte
    logic                   rx_valid_q;
    logic                   rx_err_q;
    logic                   tx_start_q;
    logic                   wr_lo;
    logic                   wr_hi;
    logic                   tx_free;                   // No frame running or pending
    byte_t                  stat;

    assign wr_lo   = i_sel & i_wr_lo;
    assign wr_hi   = i_sel & i_wr_hi;
    assign tx_free = ~(i_tx_busy | tx_start_q);

    // Control and status --------
    always_ff @(posedge i_mclk) begin
        if (!i_rst_n) begin
            prer_q     <= PRER_RESET;
            rx_valid_q <= 1'b0;
            rx_err_q   <= 1'b0;
            tx_start_q <= 1'b0;
        end else begin
            if (wr_lo && i_reg_idx == UART_PRER) prer_q[BYTE_W-1:0] <= i_wdata[BYTE_W-1:0];
            if (wr_hi && i_reg_idx == UART_PRER) prer_q[PRER_W-1:BYTE_W] <= i_wdata[PRER_W-1:BYTE_W];
            tx_start_q <= wr_lo && (i_reg_idx == UART_TXDATA) && tx_free; // Dropped while busy
            if (i_rx_done) begin                       // Receiver wins over W1C
                rx_valid_q <= 1'b1;
            end else if (wr_lo && i_reg_idx == UART_STAT && i_wdata[STAT_RXVALID]) begin
                rx_valid_q <= 1'b0;
            end
            if (i_rx_done && i_rx_err) begin
                rx_err_q <= 1'b1;                      // Sticky until cleared
            end else if (wr_lo && i_reg_idx == UART_STAT && i_wdata[STAT_RXERR]) begin
                rx_err_q <= 1'b0;
            end
        end
    end

    // Payload --------
    always_ff @(posedge i_mclk) begin
        if (wr_lo && i_reg_idx == UART_TXDATA && tx_free) tx_byte_q <= i_wdata[BYTE_W-1:0];
        if (i_rx_done) rx_buf_q <= i_rx_byte;          // New frame overwrites
    end

    always_comb begin
        stat               = '0;
        stat[STAT_TXBUSY]  = i_tx_busy;
        stat[STAT_RXVALID] = rx_valid_q;
        stat[STAT_RXERR]   = rx_err_q;
        case (i_reg_idx)
            UART_PRER:   o_rdata = prer_q;
            UART_TXDATA: o_rdata = {{(PER_DW-BYTE_W){1'b0}}, tx_byte_q};
            UART_RXDATA: o_rdata = {{(PER_DW-BYTE_W){1'b0}}, rx_buf_q};
            UART_STAT:   o_rdata = {{(PER_DW-BYTE_W){1'b0}}, stat};
            default:     o_rdata = '0;
        endcase
    end

    assign o_tx_start = tx_start_q;
    assign o_tx_byte  = tx_byte_q;
    assign o_prer     = prer_q;

endmodule

// File: rtl/per_bus_ctrl.sv
`timescale 1ns/10ps
module per_bus_ctrl import per_bus_pkg::*;
(
    input   per_addr_t              i_per_addr,
    input   per_data_t              i_per_din,
    input   logic                   i_per_en,
    input   logic   [PER_WEW-1:0]   i_per_we,
    input   per_data_t              i_uart_rdata,
    input   per_data_t              i_gpio_rdata,

    output  logic                   o_uart_sel,
    output  logic                   o_gpio_sel,
    output  reg_idx_t               o_reg_idx,
    output  logic                   o_wr_lo,
    output  logic                   o_wr_hi,
    output  per_data_t              o_wdata,
    output  per_data_t              o_per_dout
);

    logic   hit_uart;                                  // Address inside UART block
    logic   hit_gpio;                                  // Address inside GPIO block
    logic   rd_cyc;                                    // Enabled cycle, no write lanes

    // Block decode --------
    assign hit_uart = (i_per_addr[PER_AW-1:BLK_SPAN_W] == UART_BASE[PER_AW-1:BLK_SPAN_W]);
    assign hit_gpio = (i_per_addr[PER_AW-1:BLK_SPAN_W] == GPIO_BASE[PER_AW-1:BLK_SPAN_W]);

    assign o_uart_sel = i_per_en & hit_uart;           // Only valid in enabled cycles
    assign o_gpio_sel = i_per_en & hit_gpio;
    assign o_reg_idx  = i_per_addr[BLK_SPAN_W-1:0];    // Word offset in block

    // Write lanes --------
    assign o_wr_lo = i_per_en & i_per_we[0];           // Low byte
    assign o_wr_hi = i_per_en & i_per_we[1];           // High byte
    assign o_wdata = i_per_din;

    // Read mux --------
    assign rd_cyc = i_per_en & ~(|i_per_we);

    // Zero outside read cycles and unmapped space
    always_comb begin
        if (rd_cyc && hit_uart) begin
            o_per_dout = i_uart_rdata;
        end else if (rd_cyc && hit_gpio) begin
            o_per_dout = i_gpio_rdata;
        end else begin
            o_per_dout = '0;
        end
    end

endmodule

// File: common/periph_pkg.sv
package periph_pkg;

    localparam int BYTE_W     = 8;                     // UART and GPIO payload width
    localparam int PRER_W     = 16;                    // UART prescaler width
    localparam int FRAME_BITS = 10;                    // 8N1 frame, start + data + stop

    typedef logic [BYTE_W-1:0] byte_t;

    // UART registers --------
    localparam logic [2:0] UART_PRER   = 3'd0;         // Clocks per bit minus one
    localparam logic [2:0] UART_TXDATA = 3'd1;         // Write starts a frame
    localparam logic [2:0] UART_RXDATA = 3'd2;         // Read only
    localparam logic [2:0] UART_STAT   = 3'd3;         // Status

    localparam int STAT_TXBUSY  = 0;                   // Transmitter running
    localparam int STAT_RXVALID = 1;                   // W1C
    localparam int STAT_RXERR   = 2;                   // W1C, low stop bit seen

    localparam logic [PRER_W-1:0] PRER_RESET = 16'd15;

    // GPIO registers --------
    localparam logic [2:0] GPIO_DIR0 = 3'd0;           // 1 = output
    localparam logic [2:0] GPIO_OUT0 = 3'd1;
    localparam logic [2:0] GPIO_IN0  = 3'd2;           // Synchronized pins, read only
    localparam logic [2:0] GPIO_DIR1 = 3'd3;
    localparam logic [2:0] GPIO_OUT1 = 3'd4;
    localparam logic [2:0] GPIO_IN1  = 3'd5;

endpackage

// File: common/per_bus_pkg.sv
package per_bus_pkg;

    // Bus geometry --------
    localparam int PER_AW     = 14;                    // Word address width
    localparam int PER_DW     = 16;                    // Data width
    localparam int PER_WEW    = 2;                     // One write enable per byte lane
    localparam int REG_IDX_W  = 3;                     // Register index inside a block
    localparam int BLK_SPAN_W = 3;                     // Low address bits taken by the index

    // Address map --------
    // Word addresses, byte address shifted right by one
    localparam logic [PER_AW-1:0] UART_BASE = 14'h0040; // Byte address 0x0080
    localparam logic [PER_AW-1:0] GPIO_BASE = 14'h0048; // Byte address 0x0090

    typedef logic [PER_AW-1:0]    per_addr_t;
    typedef logic [PER_DW-1:0]    per_data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage
